// ==== design/sfp_mgmt_pkg.sv ====
package sfp_mgmt_pkg;

   // --------------------
   // Bus widths
   // --------------------
   localparam int WB_ADR_W  = 8;
   localparam int WB_DATA_W = 32;

   typedef logic [WB_DATA_W-1:0] wb_data_t;

   // Register index is taken from address bits 5..2
   localparam int REG_IDX_W = 4;

   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // --------------------
   // Core control word
   // --------------------
   localparam int CTRL_W = 11;

   typedef logic [CTRL_W-1:0] ctrl_word_t;

   localparam int CTRL_CHK_EN_BIT  = 0;   // BIST checker enable
   localparam int CTRL_GEN_EN_BIT  = 1;   // BIST generator enable
   localparam int CTRL_LOOP_EN_BIT = 2;   // Loopback enable
   localparam int CTRL_RATE_LSB    = 3;
   localparam int CTRL_RATE_W      = 6;   // Generator rate field
   localparam int CTRL_PHY_RST_BIT = 9;
   localparam int CTRL_MAC_CLR_BIT = 10;

   // --------------------
   // Status and counters
   // --------------------
   localparam int LOCK_CNT_W = 20;
   localparam int BIST_CNT_W = 48;

   // Clock and PLL lock flags, tied to their healthy values
   localparam logic [4:0] STATUS_FIXED_BITS = 5'b11010;

   // Readback slots, any other index reads zero
   typedef enum logic [REG_IDX_W-1:0] {
      RB_CORE_STATUS  = 4'd0,
      RB_OVERRUNS     = 4'd1,
      RB_CHECKSUM_ERR = 4'd2,
      RB_BIST_SAMPS   = 4'd3,
      RB_BIST_ERRORS  = 4'd4
   } rb_slot_e;

endpackage

// ==== design/wb_reg_port.sv ====
`timescale 1ns/10ps

module wb_reg_port (
   input  logic                                 bus_clk,
   input  logic                                 arst_n_i,

   // Wishbone slave
   input  logic [sfp_mgmt_pkg::WB_ADR_W-1:0]    wb_adr_i,
   input  logic                                 wb_cyc_i,
   input  logic                                 wb_stb_i,
   input  logic                                 wb_we_i,
   input  sfp_mgmt_pkg::wb_data_t               wb_dat_i,
   output logic                                 wb_ack_o,
   output sfp_mgmt_pkg::wb_data_t               wb_dat_o,

   // Register side
   output logic                                 wr_stb_o,
   output sfp_mgmt_pkg::reg_idx_t               wr_idx_o,
   output sfp_mgmt_pkg::wb_data_t               wr_data_o,
   output sfp_mgmt_pkg::reg_idx_t               rd_idx_o,
   input  sfp_mgmt_pkg::wb_data_t               rd_data_i
);

   logic                   bus_req;
   sfp_mgmt_pkg::reg_idx_t req_idx;

   // New request only while no ack is pending
   assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

   // Word address, byte lanes dropped
   assign req_idx = wb_adr_i[sfp_mgmt_pkg::REG_IDX_W+1:2];

   // --------------------
   // Register side
   // --------------------
   assign wr_stb_o  = bus_req & wb_we_i;   // Target latches on the ack edge
   assign wr_idx_o  = req_idx;
   assign wr_data_o = wb_dat_i;
   assign rd_idx_o  = req_idx;

   // --------------------
   // Ack and read data
   // --------------------
   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_ack_o <= 1'b0;
      end else begin
         wb_ack_o <= bus_req;
      end
   end

   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_dat_o <= '0;
      end else if (bus_req && !wb_we_i) begin
         // Captured together with the ack
         wb_dat_o <= rd_data_i;
      end
   end

   // Master holds its strobe through the ack cycle
   strobe_held_a : assert property (
      @(posedge bus_clk) disable iff (!arst_n_i)
      bus_req |=> wb_cyc_i && wb_stb_i
   );

endmodule

// ==== design/core_control_reg.sv ====
`timescale 1ns/10ps

module core_control_reg #(
   parameter sfp_mgmt_pkg::reg_idx_t CTRL_IDX = 4'd0
) (
   input  logic                                    bus_clk,
   input  logic                                    arst_n_i,

   input  logic                                    wr_stb_i,
   input  sfp_mgmt_pkg::reg_idx_t                  wr_idx_i,
   input  sfp_mgmt_pkg::wb_data_t                  wr_data_i,

   output logic                                    bist_checker_en_o,
   output logic                                    bist_gen_en_o,
   output logic                                    bist_loopback_en_o,
   output logic [sfp_mgmt_pkg::CTRL_RATE_W-1:0]    bist_gen_rate_o,
   output logic                                    phy_areset_o,
   output logic                                    mac_clear_o
);

   sfp_mgmt_pkg::ctrl_word_t ctrl_q;
   logic                     ctrl_wr;

   assign ctrl_wr = wr_stb_i && (wr_idx_i == CTRL_IDX);

   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q <= '0;
      end else if (ctrl_wr) begin
         ctrl_q <= wr_data_i[sfp_mgmt_pkg::CTRL_W-1:0];   // Upper bits dropped
      end
   end

   // --------------------
   // Field split
   // --------------------
   assign bist_checker_en_o  = ctrl_q[sfp_mgmt_pkg::CTRL_CHK_EN_BIT];
   assign bist_gen_en_o      = ctrl_q[sfp_mgmt_pkg::CTRL_GEN_EN_BIT];
   assign bist_loopback_en_o = ctrl_q[sfp_mgmt_pkg::CTRL_LOOP_EN_BIT];
   assign bist_gen_rate_o    = ctrl_q[sfp_mgmt_pkg::CTRL_RATE_LSB +: sfp_mgmt_pkg::CTRL_RATE_W];
   assign phy_areset_o       = ctrl_q[sfp_mgmt_pkg::CTRL_PHY_RST_BIT];

   // MAC clear is level, software writes it back to 0
   assign mac_clear_o        = ctrl_q[sfp_mgmt_pkg::CTRL_MAC_CLR_BIT];

   // One write strobe per bus cycle
   ctrl_write_pulse_a : assert property (
      @(posedge bus_clk) disable iff (!arst_n_i)
      wr_stb_i |=> !wr_stb_i
   );

endmodule

// ==== design/link_status_sync.sv ====
`timescale 1ns/10ps

module link_status_sync (
   input  logic bus_clk,
   input  logic arst_n_i,

   // Link clock domain levels
   input  logic channel_up_i,
   input  logic hard_err_i,
   input  logic soft_err_i,
   input  logic mac_crit_err_i,

   input  logic mac_clear_i,

   output logic channel_up_o,
   output logic hard_err_o,
   output logic soft_err_o,
   output logic crit_err_latched_o
);

   localparam int N_SYNC = 4;

   logic [N_SYNC-1:0] async_in;
   logic [N_SYNC-1:0] meta_q;   // First stage, may go metastable
   logic [N_SYNC-1:0] sync_q;
   logic              crit_err_sync;

   assign async_in = {mac_crit_err_i, soft_err_i, hard_err_i, channel_up_i};

   // --------------------
   // Two-flop synchronizers
   // --------------------
   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= async_in;
         sync_q <= meta_q;
      end
   end

   assign channel_up_o  = sync_q[0];
   assign hard_err_o    = sync_q[1];
   assign soft_err_o    = sync_q[2];
   assign crit_err_sync = sync_q[3];

   // Sticky critical error, software clears it through mac_clear
   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         crit_err_latched_o <= 1'b0;
      end else if (mac_clear_i) begin
         crit_err_latched_o <= 1'b0;
      end else if (crit_err_sync) begin
         crit_err_latched_o <= 1'b1;
      end
   end

   // Each link level lasts at least two bus clocks
   link_level_width_a : assert property (
      @(posedge bus_clk) disable iff (!arst_n_i)
      !$stable(async_in) |=> $stable(async_in)
   );

endmodule

// ==== design/status_readback.sv ====
`timescale 1ns/10ps

module status_readback (
   input  logic                                   bus_clk,
   input  logic                                   arst_n_i,

   // Readback port
   input  sfp_mgmt_pkg::reg_idx_t                 rd_idx_i,
   output sfp_mgmt_pkg::wb_data_t                 rd_data_o,

   // BIST state
   input  logic                                   bist_checker_en_i,
   input  logic                                   bist_checker_locked_i,

   // Synchronized link status
   input  logic                                   channel_up_i,
   input  logic                                   hard_err_i,
   input  logic                                   soft_err_i,
   input  logic                                   crit_err_latched_i,

   // MAC counters
   input  logic [31:0]                            overruns_i,
   input  logic [31:0]                            checksum_errors_i,
   input  logic [sfp_mgmt_pkg::BIST_CNT_W-1:0]    bist_checker_samps_i,
   input  logic [sfp_mgmt_pkg::BIST_CNT_W-1:0]    bist_checker_errors_i
);

   logic [sfp_mgmt_pkg::LOCK_CNT_W-1:0] lock_cnt_q;
   sfp_mgmt_pkg::wb_data_t              core_status;

   // --------------------
   // Lock latency counter
   // --------------------
   always_ff @(posedge bus_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         lock_cnt_q <= '0;
      end else if (!bist_checker_en_i && !bist_checker_locked_i) begin
         lock_cnt_q <= '0;                 // Idle, ready for next attempt
      end else if (bist_checker_en_i && !bist_checker_locked_i) begin
         lock_cnt_q <= lock_cnt_q + 1'b1;  // Hunting for lock
      end
   end

   // --------------------
   // Core status word
   // --------------------
   assign core_status = {
      6'h00,                                    // [31:26]
      crit_err_latched_i,                       // [25]
      sfp_mgmt_pkg::STATUS_FIXED_BITS,          // [24:20] PLL flags
      lock_cnt_q[sfp_mgmt_pkg::LOCK_CNT_W-1:4], // [19:4]
      bist_checker_locked_i,                    // [3]
      soft_err_i,                               // [2]
      hard_err_i,                               // [1]
      channel_up_i                              // [0]
   };

   // Readback mux
   always_comb begin
      case (sfp_mgmt_pkg::rb_slot_e'(rd_idx_i))
         sfp_mgmt_pkg::RB_CORE_STATUS:  rd_data_o = core_status;
         sfp_mgmt_pkg::RB_OVERRUNS:     rd_data_o = overruns_i;
         sfp_mgmt_pkg::RB_CHECKSUM_ERR: rd_data_o = checksum_errors_i;
         sfp_mgmt_pkg::RB_BIST_SAMPS: begin
            // Sample count in units of 2^16
            rd_data_o = bist_checker_samps_i[sfp_mgmt_pkg::BIST_CNT_W-1 -: 32];
         end
         sfp_mgmt_pkg::RB_BIST_ERRORS:  rd_data_o = bist_checker_errors_i[31:0];  // Unscaled
         default:                       rd_data_o = '0;
      endcase
   end

   // The checker can only lock while it is enabled
   lock_needs_enable_a : assert property (
      @(posedge bus_clk) disable iff (!arst_n_i)
      $rose(bist_checker_locked_i) |-> bist_checker_en_i
   );

endmodule

// ==== design/aurora_mgmt_top.sv ====
`timescale 1ns/10ps

module aurora_mgmt_top #(
   parameter sfp_mgmt_pkg::reg_idx_t CTRL_IDX = 4'd0
) (
   input  logic                                   bus_clk,
   input  logic                                   arst_n_i,

   // Wishbone slave
   input  logic [sfp_mgmt_pkg::WB_ADR_W-1:0]      wb_adr_i,
   input  logic                                   wb_cyc_i,
   input  logic                                   wb_stb_i,
   input  logic                                   wb_we_i,
   input  sfp_mgmt_pkg::wb_data_t                 wb_dat_i,
   output logic                                   wb_ack_o,
   output sfp_mgmt_pkg::wb_data_t                 wb_dat_o,

   // Core control
   output logic                                   bist_checker_en_o,
   output logic                                   bist_gen_en_o,
   output logic                                   bist_loopback_en_o,
   output logic [sfp_mgmt_pkg::CTRL_RATE_W-1:0]   bist_gen_rate_o,
   output logic                                   phy_areset_o,
   output logic                                   mac_clear_o,

   // Link status, link clock domain
   input  logic                                   channel_up_i,
   input  logic                                   hard_err_i,
   input  logic                                   soft_err_i,
   input  logic                                   mac_crit_err_i,

   // MAC counters and BIST lock
   input  logic                                   bist_checker_locked_i,
   input  logic [31:0]                            overruns_i,
   input  logic [31:0]                            checksum_errors_i,
   input  logic [sfp_mgmt_pkg::BIST_CNT_W-1:0]    bist_checker_samps_i,
   input  logic [sfp_mgmt_pkg::BIST_CNT_W-1:0]    bist_checker_errors_i,

   output logic [15:0]                            phy_status_o
);

   logic                   wr_stb;
   sfp_mgmt_pkg::reg_idx_t wr_idx, rd_idx;
   sfp_mgmt_pkg::wb_data_t wr_data, rd_data;
   logic                   channel_up_bclk, hard_err_bclk, soft_err_bclk, crit_err_latched;

   // Raw PHY levels, no synchronization
   assign phy_status_o = {14'd0, hard_err_i, channel_up_i};

   wb_reg_port wb_reg_port_i (
      .bus_clk, .arst_n_i,
      .wb_adr_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_dat_i, .wb_ack_o, .wb_dat_o,
      .wr_stb_o (wr_stb), .wr_idx_o (wr_idx), .wr_data_o (wr_data),
      .rd_idx_o (rd_idx), .rd_data_i (rd_data)
   );

   core_control_reg #(.CTRL_IDX(CTRL_IDX)) core_control_reg_i (
      .bus_clk, .arst_n_i,
      .wr_stb_i (wr_stb), .wr_idx_i (wr_idx), .wr_data_i (wr_data),
      .bist_checker_en_o, .bist_gen_en_o, .bist_loopback_en_o, .bist_gen_rate_o,
      .phy_areset_o, .mac_clear_o
   );

   link_status_sync link_status_sync_i (
      .bus_clk, .arst_n_i,
      .channel_up_i, .hard_err_i, .soft_err_i, .mac_crit_err_i,
      .mac_clear_i (mac_clear_o),
      .channel_up_o (channel_up_bclk), .hard_err_o (hard_err_bclk),
      .soft_err_o (soft_err_bclk), .crit_err_latched_o (crit_err_latched)
   );

   status_readback status_readback_i (
      .bus_clk, .arst_n_i,
      .rd_idx_i (rd_idx), .rd_data_o (rd_data),
      .bist_checker_en_i (bist_checker_en_o), .bist_checker_locked_i,
      .channel_up_i (channel_up_bclk), .hard_err_i (hard_err_bclk),
      .soft_err_i (soft_err_bclk), .crit_err_latched_i (crit_err_latched),
      .overruns_i, .checksum_errors_i, .bist_checker_samps_i, .bist_checker_errors_i
   );

endmodule

// ==== tb/tb_aurora_mgmt_checks.svh ====
`ifndef TB_AURORA_MGMT_CHECKS_SVH
`define TB_AURORA_MGMT_CHECKS_SVH

// --------------------
// Failure handling
// --------------------
task automatic abort_run(input string reason);
   $display("%s", reason);
   $display("TEST FAILED");
   $fatal(1, "Simulation stopped at the first failure");
endtask

task automatic check_data(input string name, input sfp_mgmt_pkg::wb_data_t got,
                          input sfp_mgmt_pkg::wb_data_t exp);
   if (got !== exp) begin
      abort_run($sformatf("Error %s: got 0x%08h, expected 0x%08h", name, got, exp));
   end
endtask

task automatic check_ctrl(input string name, input sfp_mgmt_pkg::ctrl_word_t got,
                          input sfp_mgmt_pkg::ctrl_word_t exp);
   if (got !== exp) begin
      abort_run($sformatf("Error %s: got 0x%03h, expected 0x%03h", name, got, exp));
   end
endtask

// --------------------
// Reference readback
// --------------------
function automatic sfp_mgmt_pkg::wb_data_t expected_readback(
   input sfp_mgmt_pkg::reg_idx_t idx,
   input logic [19:0]            lock_cnt
);
   sfp_mgmt_pkg::wb_data_t word;
   case (idx)
      4'd0: begin
         // PLL flags read 1,1,0,1,0 from bit 24 down
         word = {6'd0, crit_latch_model, 5'b11010, lock_cnt[19:4],
                 locked, soft_err, hard_err, channel_up};
      end
      4'd1:    word = overruns;
      4'd2:    word = checksum_errors;
      4'd3:    word = bist_samps[47:16];   // Units of 2^16 samples
      4'd4:    word = bist_errors[31:0];
      default: word = '0;
   endcase
   return word;
endfunction

`endif

// ==== tb/tb_aurora_mgmt.sv ====
`timescale 1ns/10ps

module tb_aurora_mgmt;

   localparam int                     ACK_TIMEOUT  = 8;
   localparam int                     POLL_TIMEOUT = 40;
   localparam sfp_mgmt_pkg::reg_idx_t CTRL_IDX     = 4'd0;

   logic                     bus_clk;
   logic                     arst_n;
   logic [7:0]               wb_adr;
   logic                     wb_cyc;
   logic                     wb_stb;
   logic                     wb_we;
   sfp_mgmt_pkg::wb_data_t   wb_dat_w;
   sfp_mgmt_pkg::wb_data_t   wb_dat_r;
   logic                     wb_ack;
   logic                     chk_en;
   logic                     gen_en;
   logic                     loop_en;
   logic [5:0]               gen_rate;
   logic                     phy_rst;
   logic                     mac_clr;
   logic                     channel_up;
   logic                     hard_err;
   logic                     soft_err;
   logic                     mac_crit_err;
   logic                     locked;
   logic [31:0]              overruns;
   logic [31:0]              checksum_errors;
   logic [47:0]              bist_samps;
   logic [47:0]              bist_errors;
   logic [15:0]              phy_status;

   integer                   seed;
   sfp_mgmt_pkg::ctrl_word_t ctrl_model;      // Control word as the DUT should hold it
   sfp_mgmt_pkg::ctrl_word_t ctrl_seen;
   logic                     crit_latch_model;
   logic [19:0]              lock_model;
   logic [19:0]              lock_model_prev;
   logic [19:0]              lock_at_read;
   sfp_mgmt_pkg::wb_data_t   rd_word;
   sfp_mgmt_pkg::wb_data_t   first_word;
   sfp_mgmt_pkg::wb_data_t   wdata;

   `include "tb_aurora_mgmt_checks.svh"

   initial bus_clk = 1'b0;
   always #50 bus_clk = ~bus_clk;

   aurora_mgmt_top #(.CTRL_IDX(CTRL_IDX)) dut_i (
      .bus_clk, .arst_n_i (arst_n),
      .wb_adr_i (wb_adr), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we),
      .wb_dat_i (wb_dat_w), .wb_ack_o (wb_ack), .wb_dat_o (wb_dat_r),
      .bist_checker_en_o (chk_en), .bist_gen_en_o (gen_en), .bist_loopback_en_o (loop_en),
      .bist_gen_rate_o (gen_rate), .phy_areset_o (phy_rst), .mac_clear_o (mac_clr),
      .channel_up_i (channel_up), .hard_err_i (hard_err), .soft_err_i (soft_err),
      .mac_crit_err_i (mac_crit_err), .bist_checker_locked_i (locked),
      .overruns_i (overruns), .checksum_errors_i (checksum_errors),
      .bist_checker_samps_i (bist_samps), .bist_checker_errors_i (bist_errors),
      .phy_status_o (phy_status)
   );

   // Lock latency counter rule
   always @(posedge bus_clk or negedge arst_n) begin
      if (!arst_n) begin
         lock_model      <= '0;
         lock_model_prev <= '0;
      end else begin
         lock_model_prev <= lock_model;   // Value the mux showed last cycle
         if (!ctrl_model[sfp_mgmt_pkg::CTRL_CHK_EN_BIT] && !locked) begin
            lock_model <= '0;
         end else if (ctrl_model[sfp_mgmt_pkg::CTRL_CHK_EN_BIT] && !locked) begin
            lock_model <= lock_model + 1'b1;
         end
      end
   end

   // --------------------
   // Bus tasks
   // --------------------
   task automatic run_cycle(input logic we, input sfp_mgmt_pkg::reg_idx_t idx,
                            input sfp_mgmt_pkg::wb_data_t wr_word);
      int waited;
      waited = 0;
      @(posedge bus_clk);
      wb_adr   <= {2'b00, idx, 2'b00};
      wb_we    <= we;
      wb_dat_w <= wr_word;
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      do begin
         @(negedge bus_clk);
         waited++;
         if (waited > ACK_TIMEOUT) begin
            abort_run("Timeout: the Wishbone acknowledge never arrived");
         end
      end while (!wb_ack);
      // Ack rises on the edge after the request, seen at the second falling edge
      if (waited != 2) begin
         abort_run("The acknowledge did not arrive one cycle after the request");
      end
      rd_word      = wb_dat_r;            // Sampled mid-cycle, stable
      lock_at_read = lock_model_prev;
      ctrl_seen    = {mac_clr, phy_rst, gen_rate, loop_en, gen_en, chk_en};
      if (we && idx == CTRL_IDX) begin
         ctrl_model = wr_word[sfp_mgmt_pkg::CTRL_W-1:0];
      end
      @(posedge bus_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic poll_status(input int bit_pos, input logic level);
      int tries;
      tries = 0;
      do begin
         run_cycle(1'b0, 4'd0, '0);
         tries++;
         if (tries > POLL_TIMEOUT) begin
            abort_run("Timeout: a status bit never reached its expected level");
         end
      end while (rd_word[bit_pos] !== level);
   endtask

   task automatic read_and_check(input sfp_mgmt_pkg::reg_idx_t idx);
      run_cycle(1'b0, idx, '0);
      check_data("wb_dat_o", rd_word, expected_readback(idx, lock_at_read));
   endtask

   initial begin
      seed             = 32'hab1ad0ac;
      ctrl_model       = '0;
      crit_latch_model = 1'b0;
      arst_n          <= 1'b0;
      wb_adr          <= '0;
      wb_cyc          <= 1'b0;
      wb_stb          <= 1'b0;
      wb_we           <= 1'b0;
      wb_dat_w        <= '0;
      channel_up      <= 1'b0;
      hard_err        <= 1'b0;
      soft_err        <= 1'b0;
      mac_crit_err    <= 1'b0;
      locked          <= 1'b0;
      overruns        <= '0;
      checksum_errors <= '0;
      bist_samps      <= '0;
      bist_errors     <= '0;
      repeat (10) @(posedge bus_clk);
      arst_n <= 1'b1;

      // Reset values
      @(negedge bus_clk);
      check_ctrl("control outputs", {mac_clr, phy_rst, gen_rate, loop_en, gen_en, chk_en}, '0);
      read_and_check(4'd0);

      // Control register writes
      for (int n = 0; n < 8; n++) begin
         wdata = $random(seed);
         run_cycle(1'b1, CTRL_IDX, wdata);
         check_ctrl("control outputs", ctrl_seen, wdata[sfp_mgmt_pkg::CTRL_W-1:0]);
      end
      run_cycle(1'b1, 4'd5, $random(seed));   // Other index, no effect
      check_ctrl("control outputs", ctrl_seen, ctrl_model);
      run_cycle(1'b1, CTRL_IDX, 32'h0);

      // Counter slots
      @(posedge bus_clk);
      overruns        <= $random(seed);
      checksum_errors <= $random(seed);
      bist_samps      <= {16'($random(seed)), 32'($random(seed))};
      bist_errors     <= {16'($random(seed)), 32'($random(seed))};
      for (int i = 1; i <= 7; i++) begin
         read_and_check(4'(i));
      end

      // Link status through the synchronizers
      @(posedge bus_clk);
      channel_up <= 1'b1;
      soft_err   <= 1'b1;
      @(negedge bus_clk);
      check_data("phy_status_o", {16'd0, phy_status}, 32'h0000_0001);
      repeat (2) @(posedge bus_clk);
      hard_err   <= 1'b1;
      @(negedge bus_clk);
      check_data("phy_status_o", {16'd0, phy_status}, 32'h0000_0003);
      poll_status(0, 1'b1);
      poll_status(1, 1'b1);
      poll_status(2, 1'b1);
      read_and_check(4'd0);

      // Critical error latch
      @(posedge bus_clk);
      mac_crit_err <= 1'b1;
      repeat (3) @(posedge bus_clk);
      mac_crit_err <= 1'b0;
      poll_status(25, 1'b1);
      crit_latch_model = 1'b1;
      repeat (4) @(posedge bus_clk);
      read_and_check(4'd0);
      run_cycle(1'b1, CTRL_IDX, 32'h0000_0400);   // MAC clear
      run_cycle(1'b1, CTRL_IDX, 32'h0);
      crit_latch_model = 1'b0;
      read_and_check(4'd0);

      // Lock latency
      run_cycle(1'b1, CTRL_IDX, 32'h0000_0001);
      read_and_check(4'd0);
      first_word = rd_word;
      read_and_check(4'd0);
      if (rd_word[19:4] < first_word[19:4]) begin
         abort_run("The lock latency count went down while the checker hunted for lock");
      end
      repeat (40) @(posedge bus_clk);
      locked <= 1'b1;
      read_and_check(4'd0);
      if (rd_word[19:4] == 16'd0) begin
         abort_run("The lock latency count is zero after the checker locked");
      end
      first_word = rd_word;
      repeat (5) @(posedge bus_clk);
      read_and_check(4'd0);
      check_data("lock latency field", {16'd0, rd_word[19:4]}, {16'd0, first_word[19:4]});
      run_cycle(1'b1, CTRL_IDX, 32'h0);
      @(posedge bus_clk);
      locked <= 1'b0;
      read_and_check(4'd0);
      check_data("lock latency field", {16'd0, rd_word[19:4]}, 32'd0);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+tb
design/sfp_mgmt_pkg.sv
design/wb_reg_port.sv
design/core_control_reg.sv
design/link_status_sync.sv
design/status_readback.sv
design/aurora_mgmt_top.sv
tb/tb_aurora_mgmt.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_aurora_mgmt -f compile.f \
   -o sim_aurora_mgmt || exit 1
sim_out=$(./obj_dir/sim_aurora_mgmt 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "TEST PASSED" && exit 0 || exit 1
